/* sim/wb_mem_trace.txt */
# op addr data sel expected, all hex; W write, R read, E write that must get err
# expected is the read data on R lines and 0 elsewhere; bank k starts at k*0x400
# full word write and readback in every bank
W 00000004 a5a5a5a5 f 00000000
R 00000004 00000000 f a5a5a5a5
W 000004fc 12345678 f 00000000
R 000004fc 00000000 f 12345678
W 00000810 cafef00d f 00000000
R 00000810 00000000 f cafef00d
W 00000ffc deadbeef f 00000000
R 00000ffc 00000000 f deadbeef
W 00000000 0badf00d f 00000000
R 00000000 00000000 f 0badf00d
W 000003fc 87654321 f 00000000
R 000003fc 00000000 f 87654321
# byte lanes in bank 0
W 00000020 11111111 f 00000000
W 00000020 aabbccdd 1 00000000
R 00000020 00000000 f 111111dd
W 00000020 aabbccdd 6 00000000
R 00000020 00000000 f 11bbccdd
W 00000020 00000000 8 00000000
R 00000020 00000000 f 00bbccdd
W 00000020 ffffffff 0 00000000
R 00000020 00000000 f 00bbccdd
# byte lanes in banks 2 and 3
W 00000a40 01020304 f 00000000
W 00000a40 f0e0d0c0 5 00000000
R 00000a40 00000000 f 01e003c0
W 00000a40 f0e0d0c0 a 00000000
R 00000a40 00000000 f f0e0d0c0
W 00000c44 76543210 f 00000000
W 00000c44 89abcdef c 00000000
R 00000c44 00000000 f 89ab3210
# same word index in all four banks
W 00000040 b0b0b0b0 f 00000000
W 00000440 b1b1b1b1 f 00000000
W 00000840 b2b2b2b2 f 00000000
W 00000c40 b3b3b3b3 f 00000000
R 00000040 00000000 f b0b0b0b0
R 00000440 00000000 f b1b1b1b1
R 00000840 00000000 f b2b2b2b2
R 00000c40 00000000 f b3b3b3b3
W 00000840 00000000 3 00000000
R 00000040 00000000 f b0b0b0b0
R 00000840 00000000 f b2b20000
R 00000c40 00000000 f b3b3b3b3
# unpopulated addresses, low bits alias words written above
E 00001040 eeeeeeee f 00000000
E 00001440 eeeeeeee f 00000000
E 80000c40 eeeeeeee f 00000000
E 00010004 eeeeeeee f 00000000
E 00001c44 eeeeeeee 3 00000000
R 00000040 00000000 f b0b0b0b0
R 00000440 00000000 f b1b1b1b1
R 00000c40 00000000 f b3b3b3b3
R 00000004 00000000 f a5a5a5a5
R 00000c44 00000000 f 89ab3210
# final sweep over earlier words
R 000004fc 00000000 f 12345678
R 00000810 00000000 f cafef00d
R 00000ffc 00000000 f deadbeef
R 00000020 00000000 f 00bbccdd
R 000003fc 00000000 f 87654321
R 00000a40 00000000 f f0e0d0c0

/* filelist.f */
rtl/wb_mem_pkg.sv
rtl/wb_bank_decoder.sv
rtl/wb_sram_bank.sv
rtl/wb_resp_merge.sv
rtl/wb_mem_subsys.sv
sim/tb_wb_mem_subsys.sv

/* Makefile */
# Verilator build and run of the trace-driven testbench

TOP := tb_wb_mem_subsys

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# the run passes only if the testbench printed its pass line
test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

/* sim/tb_wb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_wb_mem_subsys;
    import wb_mem_pkg::*;

    localparam int    N_BANKS     = 4;
    localparam int    BANK_WORDS  = 256;
    localparam int    CLK_PERIOD  = 4;      // ns
    localparam int    RST_CYCLES  = 10;
    localparam int    WR_LATENCY  = 1;      // cycles from request to ack
    localparam int    RD_LATENCY  = 2;
    localparam int    ERR_LATENCY = 1;
    localparam string TRACE_FILE  = "sim/wb_mem_trace.txt";

    logic              clk;
    logic              rst_n_i;
    logic              wb_cyc_i;
    logic              wb_stb_i;
    logic              wb_we_i;
    logic [ADDR_W-1:0] wb_adr_i;
    logic [DATA_W-1:0] wb_dat_i;
    logic [SEL_W-1:0]  wb_sel_i;
    logic              wb_ack_o;
    logic              wb_err_o;
    logic [DATA_W-1:0] wb_dat_o;

    // trace contents, one entry per transaction
    byte               op_q  [$];
    logic [ADDR_W-1:0] adr_q [$];
    logic [DATA_W-1:0] dat_q [$];
    logic [SEL_W-1:0]  sel_q [$];
    logic [DATA_W-1:0] exp_q [$];

    int cycle_cnt   = 0;
    int cycle_limit = 0;   // 0 until the trace is loaded

    wb_mem_subsys #(
        .N_BANKS    (N_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) UUT (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_sel_i   (wb_sel_i),
        .wb_ack_o   (wb_ack_o),
        .wb_err_o   (wb_err_o),
        .wb_dat_o   (wb_dat_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    // each transaction needs at most 4 cycles, 6 leaves headroom
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            stop_with_failure($sformatf("timeout: the run did not finish within %0d clock cycles",
                                        cycle_limit));
        end
    end

    task automatic load_trace();
        int                fd;
        int                n;
        string             line;
        byte               op;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic [SEL_W-1:0]  sel;
        logic [DATA_W-1:0] exp_val;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            stop_with_failure({"could not open the trace file ", TRACE_FILE});
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin   // skip blank and comment lines
                    n = $sscanf(line, "%c %h %h %h %h", op, adr, dat, sel, exp_val);
                    if (n != 5 || (op != "W" && op != "R" && op != "E")) begin
                        stop_with_failure({"the trace file has a malformed line: ", line});
                    end else begin
                        op_q.push_back(op);
                        adr_q.push_back(adr);
                        dat_q.push_back(dat);
                        sel_q.push_back(sel);
                        exp_q.push_back(exp_val);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one request: drive, wait for the response, check it, then idle a cycle
    task automatic run_txn(input byte op, input logic [ADDR_W-1:0] adr,
                           input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
                           input logic [DATA_W-1:0] exp_val);
        int                lat;
        int                exp_lat;
        logic              got_ack;
        logic              got_err;
        logic [DATA_W-1:0] got_dat;
        exp_lat = (op == "R") ? RD_LATENCY : ((op == "W") ? WR_LATENCY : ERR_LATENCY);
        @(posedge clk);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = (op != "R");   // E lines are writes to an unpopulated address
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_sel_i = sel;
        lat      = 0;
        got_ack  = 1'b0;
        got_err  = 1'b0;
        while (!got_ack && !got_err) begin
            @(negedge clk);   // outputs settled mid-cycle
            got_ack = wb_ack_o;
            got_err = wb_err_o;
            got_dat = wb_dat_o;
            if (!got_ack && !got_err) begin
                lat++;
            end
        end
        assert (!(got_ack && got_err))
            else stop_with_failure($sformatf("ack and err were high together for address %h", adr));
        if (op == "E") begin
            assert (!got_ack)
                else stop_with_failure($sformatf("error: wb_ack_o at %h got %h expected %h",
                                                 adr, got_ack, 1'b0));
        end else begin
            assert (!got_err)
                else stop_with_failure($sformatf("error: wb_err_o at %h got %h expected %h",
                                                 adr, got_err, 1'b0));
        end
        assert (lat == exp_lat)
            else stop_with_failure($sformatf("error: %s latency at %h got %0h expected %0h",
                                             got_err ? "wb_err_o" : "wb_ack_o", adr, lat, exp_lat));
        if (op == "R") begin
            assert (got_dat == exp_val)
                else stop_with_failure($sformatf("error: wb_dat_o at %h got %h expected %h",
                                                 adr, got_dat, exp_val));
        end
        @(posedge clk);
        #1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(negedge clk);
        assert (!wb_ack_o && !wb_err_o)
            else stop_with_failure($sformatf("a response stayed high after the one for %h", adr));
    endtask

    initial begin
        rst_n_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        load_trace();
        cycle_limit = RST_CYCLES + 6 * op_q.size();
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            run_txn(op_q[i], adr_q[i], dat_q[i], sel_q[i], exp_q[i]);
        end
        if (op_q.size() > 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_failure("the trace held no transactions to run");
        end
    end

endmodule

/* rtl/wb_mem_subsys.sv */
`timescale 1ns/1ps

module wb_mem_subsys #(
    parameter int N_BANKS    = 4,
    parameter int BANK_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          rst_n_i,

    // Wishbone classic slave
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [wb_mem_pkg::ADDR_W-1:0] wb_adr_i,
    input  logic [wb_mem_pkg::DATA_W-1:0] wb_dat_i,
    input  logic [wb_mem_pkg::SEL_W-1:0]  wb_sel_i,
    output logic                          wb_ack_o,
    output logic                          wb_err_o,
    output logic [wb_mem_pkg::DATA_W-1:0] wb_dat_o
);
    import wb_mem_pkg::*;

    localparam int IDX_W = $clog2(BANK_WORDS);

    logic [N_BANKS-1:0]        bank_stb;
    logic [IDX_W-1:0]          word_idx;   // shared by all banks
    logic [N_BANKS-1:0]        bank_ack;
    logic [N_BANKS*DATA_W-1:0] bank_rdata;

    wb_bank_decoder #(
        .N_BANKS    (N_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) u_decoder (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_adr_i   (wb_adr_i),
        .bank_stb_o (bank_stb),
        .word_idx_o (word_idx),
        .wb_err_o   (wb_err_o)
    );

    // we, sel and write data fan out to every bank, only the strobed one acts
    for (genvar k = 0; k < N_BANKS; k++) begin : gen_bank
        wb_sram_bank #(
            .BANK_WORDS (BANK_WORDS)
        ) u_bank (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .stb_i      (bank_stb[k]),
            .we_i       (wb_we_i),
            .sel_i      (wb_sel_i),
            .word_idx_i (word_idx),
            .dat_i      (wb_dat_i),
            .ack_o      (bank_ack[k]),
            .dat_o      (bank_rdata[k*DATA_W +: DATA_W])
        );
    end

    wb_resp_merge #(
        .N_BANKS      (N_BANKS)
    ) u_merge (
        .bank_ack_i   (bank_ack),
        .bank_rdata_i (bank_rdata),
        .wb_ack_o     (wb_ack_o),
        .wb_dat_o     (wb_dat_o)
    );

endmodule

/* rtl/wb_resp_merge.sv */
`timescale 1ns/1ps

module wb_resp_merge #(
    parameter int N_BANKS = 4
) (
    input  logic [N_BANKS-1:0]                    bank_ack_i,
    input  logic [N_BANKS*wb_mem_pkg::DATA_W-1:0] bank_rdata_i,
    output logic                                  wb_ack_o,
    output logic [wb_mem_pkg::DATA_W-1:0]         wb_dat_o
);
    import wb_mem_pkg::*;

    logic [DATA_W-1:0] dat_mux;

    // only one bank answers per request
    assign wb_ack_o = |bank_ack_i;

    // AND-OR mux keyed by the ack bits, zero when nobody answers
    always_comb begin
        dat_mux = '0;
        for (int k = 0; k < N_BANKS; k++) begin
            if (bank_ack_i[k]) begin
                dat_mux = dat_mux | bank_rdata_i[k*DATA_W +: DATA_W];
            end
        end
    end

    assign wb_dat_o = dat_mux;

    // bank acks are registered and stay unknown until the first reset edge
    always_comb begin
        a_ack_onehot0: assert ($isunknown(bank_ack_i) || $onehot0(bank_ack_i))
            else $error("more than one bank acked: %h", bank_ack_i);
    end

endmodule

/* rtl/wb_sram_bank.sv */
`timescale 1ns/1ps

module wb_sram_bank #(
    parameter int BANK_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          stb_i,      // cyc & stb & bank select
    input  logic                          we_i,
    input  logic [wb_mem_pkg::SEL_W-1:0]  sel_i,
    input  logic [$clog2(BANK_WORDS)-1:0] word_idx_i,
    input  logic [wb_mem_pkg::DATA_W-1:0] dat_i,
    output logic                          ack_o,
    output logic [wb_mem_pkg::DATA_W-1:0] dat_o
);
    import wb_mem_pkg::*;

    logic [SEL_W-1:0]  wen;
    logic              rd_pend_q;   // read issued, data lands this cycle
    logic              ack_q;
    logic [DATA_W-1:0] rdata_q;

    logic [DATA_W-1:0] mem_q [BANK_WORDS];

    // byte write enables, one per lane
    assign wen = sel_i & {SEL_W{we_i & stb_i}};

    // synchronous SRAM, read-before-write on the same port
    always_ff @(posedge clk) begin
        if (stb_i) begin
            rdata_q <= mem_q[word_idx_i];
            for (int b = 0; b < SEL_W; b++) begin
                if (wen[b]) begin
                    mem_q[word_idx_i][b*BYTE_W +: BYTE_W] <= dat_i[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    assign dat_o = rdata_q;

    // Ack timing, counted from the first strobed cycle (cycle 0):
    //   write  bytes land at the end of cycle 0, ack in cycle 1
    //   read   data registered at the end of cycle 0, rd_pend in cycle 1,
    //          ack in cycle 2
    // A held request does not start again while ack or rd_pend is still up.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_pend_q <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            rd_pend_q <= stb_i & ~we_i & ~ack_q & ~rd_pend_q;
            if (we_i) begin
                ack_q <= stb_i & ~ack_q;
            end else begin
                ack_q <= rd_pend_q;   // read ack one cycle behind
            end
        end
    end

    assign ack_o = ack_q;

    a_ack_single: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ack_o |=> !ack_o
    ) else $error("bank ack high two cycles in a row");

    // read data is only acknowledged once the SRAM output has been loaded
    a_read_ack_pend: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (ack_o && !we_i) |-> $past(rd_pend_q)
    ) else $error("bank read ack without a pending read");

endmodule

/* rtl/wb_bank_decoder.sv */
`timescale 1ns/1ps

module wb_bank_decoder #(
    parameter int N_BANKS    = 4,
    parameter int BANK_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic [wb_mem_pkg::ADDR_W-1:0] wb_adr_i,
    output logic [N_BANKS-1:0]            bank_stb_o,
    output logic [$clog2(BANK_WORDS)-1:0] word_idx_o,
    output logic                          wb_err_o
);
    import wb_mem_pkg::*;

    // address layout: | high (must be 0) | bank | word index | byte offset |
    localparam int IDX_W    = $clog2(BANK_WORDS);
    localparam int BANK_W   = (N_BANKS > 1) ? $clog2(N_BANKS) : 1;
    localparam int BANK_LSB = BYTE_OFF_W + IDX_W;
    localparam int HI_LSB   = BANK_LSB + BANK_W;

    logic              valid;
    logic [BANK_W-1:0] bank_num;
    logic              hi_nz;      // address bits above the bank field
    logic              addr_ok;
    logic              err_q;

    assign valid    = wb_cyc_i & wb_stb_i;
    assign bank_num = wb_adr_i[BANK_LSB +: BANK_W];
    assign hi_nz    = |(wb_adr_i >> HI_LSB);

    // bank field may be wider than needed when N_BANKS is not a power of two
    assign addr_ok = !hi_nz && (32'(bank_num) < 32'(N_BANKS));

    assign word_idx_o = wb_adr_i[BYTE_OFF_W +: IDX_W];

    always_comb begin
        bank_stb_o = '0;
        for (int k = 0; k < N_BANKS; k++) begin
            if (valid && addr_ok && (32'(bank_num) == 32'(k))) begin
                bank_stb_o[k] = 1'b1;
            end
        end
    end

    // one-cycle error, held off while the previous err is still up so a
    // request that is still held is not answered twice
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= valid & ~addr_ok & ~err_q;
        end
    end

    assign wb_err_o = err_q;

    a_stb_onehot0: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $onehot0(bank_stb_o)
    ) else $error("decoder strobed more than one bank: %h", bank_stb_o);

endmodule

/* rtl/wb_mem_pkg.sv */
package wb_mem_pkg;

    // one byte lane on the bus
    localparam int unsigned BYTE_W = 8;

    // byte lanes per data word, one wb_sel bit each
    localparam int unsigned SEL_W = 4;

    // data word width seen on wb_dat_i / wb_dat_o
    localparam int unsigned DATA_W = SEL_W * BYTE_W;

    // Wishbone carries byte addresses
    localparam int unsigned ADDR_W = 32;

    // low address bits below the word, dropped by the decoder
    localparam int unsigned BYTE_OFF_W = $clog2(SEL_W);

endpackage
